// File: Bender.yml
package:
  name: adc_ctrl

sources:
  - adc_ctrl_pkg.sv
  - adc_stream_pkg.sv
  - adc_edge_detect.sv
  - adc_pwrdn_timer.sv
  - adc_sequencer.sv
  - adc_pin_driver.sv
  - adc_response.sv
  - adc_ctrl_top.sv
  - target: test
    files:
      - tb_adc_hardblock.sv
      - tb_adc_ctrl.sv

// File: adc_ctrl_pkg.sv
// ADC sequencer control definitions
// FSM state encoding shared by the sequencer, the pin driver and the top level,
// and the width of the power-down timer
`default_nettype none

package adc_ctrl_pkg;

    typedef enum logic [4:0] {
        IDLE           = 5'd0,
        PWRDWN         = 5'd1,
        PWRDWN_TSEN    = 5'd2,
        PWRDWN_DONE    = 5'd3,
        PWRUP_CH       = 5'd4,
        PWRUP_SOC      = 5'd5,
        WAIT           = 5'd6,
        GETCMD         = 5'd7,
        GETCMD_W       = 5'd8,
        PRE_CONV       = 5'd9,
        CONV           = 5'd10,
        CONV_DLY1      = 5'd11,
        PUTRESP        = 5'd12,
        PUTRESP_DLY1   = 5'd13,
        PUTRESP_DLY2   = 5'd14,
        PUTRESP_DLY3   = 5'd15,
        WAIT_PEND      = 5'd16,
        WAIT_PEND_DLY1 = 5'd17,
        PUTRESP_PEND   = 5'd18
    } ctrl_state_t;

    typedef logic [7:0] timer_t;

endpackage

`default_nettype wire

// File: adc_ctrl_top.sv
// ADC sequencer top level
// Connects the control FSM to the strobe synchronizer, the power-down timer,
// the pin driver and the response path, and sets their parameters
`timescale 1ns/1ps
`default_nettype none

module adc_ctrl_top #(
    parameter adc_ctrl_pkg::timer_t PWRDN_CYCLES = 8'd64,
    parameter adc_ctrl_pkg::timer_t TSEN_CYCLES  = 8'd64,
    parameter bit                   MASK_TS_DATA = 1'b0
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      clk_in_pll_locked,
    input  wire                      cmd_valid,
    input  wire adc_stream_pkg::channel_t cmd_channel,
    input  wire                      cmd_sop,
    input  wire                      cmd_eop,
    input  wire                      clk_dft,
    input  wire                      eoc,
    input  wire adc_stream_pkg::sample_t  dout,
    output logic                     cmd_ready,
    output logic                     rsp_valid,
    output adc_stream_pkg::channel_t rsp_channel,
    output adc_stream_pkg::sample_t  rsp_data,
    output logic                     rsp_sop,
    output logic                     rsp_eop,
    output adc_stream_pkg::channel_t chsel,
    output logic                     soc,
    output logic                     usr_pwd,
    output logic                     tsen
);

    import adc_ctrl_pkg::*;

    logic        dft_rise;
    logic        dft_fall;
    logic        eoc_fall;
    logic        timer_clear;
    logic        timer_run;
    logic        pwrdn_elapsed;
    logic        tsen_elapsed;
    ctrl_state_t state_next;
    logic        ts_select;
    logic        cmd_take;
    logic        sample_take;
    logic        rsp_load;

    adc_edge_detect u_edge_detect (
        .clk      (clk),
        .rst_n    (rst_n),
        .clk_dft  (clk_dft),
        .eoc      (eoc),
        .dft_rise (dft_rise),
        .dft_fall (dft_fall),
        .eoc_fall (eoc_fall)
    );

    adc_pwrdn_timer #(
        .PWRDN_CYCLES (PWRDN_CYCLES),
        .TSEN_CYCLES  (TSEN_CYCLES)
    ) u_pwrdn_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer_clear   (timer_clear),
        .timer_run     (timer_run),
        .pwrdn_elapsed (pwrdn_elapsed),
        .tsen_elapsed  (tsen_elapsed)
    );

    adc_sequencer u_sequencer (
        .clk               (clk),
        .rst_n             (rst_n),
        .clk_in_pll_locked (clk_in_pll_locked),
        .cmd_valid         (cmd_valid),
        .cmd_channel       (cmd_channel),
        .dft_rise          (dft_rise),
        .dft_fall          (dft_fall),
        .eoc_fall          (eoc_fall),
        .pwrdn_elapsed     (pwrdn_elapsed),
        .tsen_elapsed      (tsen_elapsed),
        .state_next        (state_next),
        .ts_select         (ts_select),
        .timer_clear       (timer_clear),
        .timer_run         (timer_run),
        .cmd_take          (cmd_take),
        .sample_take       (sample_take),
        .rsp_load          (rsp_load)
    );

    adc_pin_driver u_pin_driver (
        .clk         (clk),
        .rst_n       (rst_n),
        .state_next  (state_next),
        .ts_select   (ts_select),
        .cmd_channel (cmd_channel),
        .chsel       (chsel),
        .soc         (soc),
        .usr_pwd     (usr_pwd),
        .tsen        (tsen)
    );

    adc_response #(
        .MASK_TS_DATA (MASK_TS_DATA)
    ) u_response (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_take    (cmd_take),
        .sample_take (sample_take),
        .rsp_load    (rsp_load),
        .cmd_channel (cmd_channel),
        .cmd_sop     (cmd_sop),
        .cmd_eop     (cmd_eop),
        .dout        (dout),
        .cmd_ready   (cmd_ready),
        .rsp_valid   (rsp_valid),
        .rsp_channel (rsp_channel),
        .rsp_data    (rsp_data),
        .rsp_sop     (rsp_sop),
        .rsp_eop     (rsp_eop)
    );

endmodule

`default_nettype wire

// File: adc_edge_detect.sv
// ADC strobe synchronizer
// Brings clk_dft and eoc from the hard block into the clk domain
// and turns their edges into single-cycle pulses
`timescale 1ns/1ps
`default_nettype none

module adc_edge_detect (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  clk_dft,
    input  wire  eoc,
    output logic dft_rise,
    output logic dft_fall,
    output logic eoc_fall
);

    // Bit 1 carries clk_dft and bit 0 carries eoc
    logic [1:0] sync_q1;
    logic [1:0] sync_q2;
    logic [1:0] sync_dly;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1  <= 2'b00;
            sync_q2  <= 2'b00;
            sync_dly <= 2'b00;
        end else begin
            sync_q1  <= {clk_dft, eoc};
            sync_q2  <= sync_q1;
            sync_dly <= sync_q2;
        end
    end

    assign dft_rise = sync_q2[1] & ~sync_dly[1];
    assign dft_fall = ~sync_q2[1] & sync_dly[1];
    assign eoc_fall = ~sync_q2[0] & sync_dly[0];

endmodule

`default_nettype wire

// File: adc_pin_driver.sv
// ADC hard-block control pins
// Registers chsel, soc, usr_pwd and tsen from the state the sequencer enters
`timescale 1ns/1ps
`default_nettype none

module adc_pin_driver (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire adc_ctrl_pkg::ctrl_state_t state_next,
    input  wire                      ts_select,
    input  wire adc_stream_pkg::channel_t cmd_channel,
    output adc_stream_pkg::channel_t chsel,
    output logic                     soc,
    output logic                     usr_pwd,
    output logic                     tsen
);

    import adc_ctrl_pkg::*;
    import adc_stream_pkg::*;

    // States not listed keep every pin as it is
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chsel   <= CH_PARK;
            soc     <= 1'b0;
            usr_pwd <= 1'b1;
            tsen    <= 1'b0;
        end else begin
            case (state_next)
                IDLE: begin
                    chsel   <= CH_PARK;
                    soc     <= 1'b0;
                    usr_pwd <= 1'b1;
                    tsen    <= 1'b0;
                end
                PWRDWN: begin
                    soc     <= 1'b0;
                    usr_pwd <= 1'b1;
                end
                PWRDWN_TSEN: begin
                    soc     <= 1'b0;
                    usr_pwd <= 1'b1;
                    tsen    <= ts_select;
                end
                PWRDWN_DONE: begin
                    soc     <= 1'b0;
                    usr_pwd <= 1'b0;
                end
                PWRUP_CH: begin
                    chsel   <= CH_PARK;
                    usr_pwd <= 1'b0;
                end
                PWRUP_SOC:       soc   <= 1'b1;
                CONV, CONV_DLY1: chsel <= cmd_channel;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: adc_pwrdn_timer.sv
// Power-down timer
// Counts the cycles spent in the power-down states and flags when the
// minimum power-down time and the further temperature-sensor settling time have passed
`timescale 1ns/1ps
`default_nettype none

module adc_pwrdn_timer #(
    parameter adc_ctrl_pkg::timer_t PWRDN_CYCLES = 8'd64,
    parameter adc_ctrl_pkg::timer_t TSEN_CYCLES  = 8'd64
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  timer_clear,
    input  wire  timer_run,
    output logic pwrdn_elapsed,
    output logic tsen_elapsed
);

    import adc_ctrl_pkg::*;

    localparam timer_t TSEN_LIMIT = PWRDN_CYCLES + TSEN_CYCLES;

    timer_t count;

    // Saturates so that a long stay never wraps back below a threshold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (timer_clear) begin
            count <= '0;
        end else if (timer_run && (count != '1)) begin
            count <= count + 1'b1;
        end
    end

    assign pwrdn_elapsed = (count >= PWRDN_CYCLES);
    assign tsen_elapsed  = (count >= TSEN_LIMIT);

    thresholds_fit: assert property (
        @(posedge clk) disable iff (!rst_n)
        (int'(PWRDN_CYCLES) + int'(TSEN_CYCLES)) < (1 << $bits(timer_t))
    );

endmodule

`default_nettype wire

// File: adc_response.sv
// ADC response path
// Holds the accepted command and the sample from the hard block, acknowledges
// the command and emits the response as a single-cycle pulse
`timescale 1ns/1ps
`default_nettype none

module adc_response #(
    parameter bit MASK_TS_DATA = 1'b0
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cmd_take,
    input  wire                      sample_take,
    input  wire                      rsp_load,
    input  wire adc_stream_pkg::channel_t cmd_channel,
    input  wire                      cmd_sop,
    input  wire                      cmd_eop,
    input  wire adc_stream_pkg::sample_t  dout,
    output logic                     cmd_ready,
    output logic                     rsp_valid,
    output adc_stream_pkg::channel_t rsp_channel,
    output adc_stream_pkg::sample_t  rsp_data,
    output logic                     rsp_sop,
    output logic                     rsp_eop
);

    import adc_stream_pkg::*;

    channel_t cmd_channel_q;
    logic     cmd_sop_q;
    logic     cmd_eop_q;
    sample_t  sample_q;
    logic     mask_data;

    // The response always belongs to the command taken one conversion earlier
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            cmd_channel_q <= cmd_channel;
            cmd_sop_q     <= cmd_sop;
            cmd_eop_q     <= cmd_eop;
        end
        if (sample_take) begin
            sample_q <= dout;
        end
    end

    assign mask_data = MASK_TS_DATA && (cmd_channel_q == CH_TEMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ready   <= 1'b0;
            rsp_valid   <= 1'b0;
            rsp_channel <= '0;
            rsp_data    <= '0;
            rsp_sop     <= 1'b0;
            rsp_eop     <= 1'b0;
        end else begin
            cmd_ready   <= cmd_take;
            rsp_valid   <= rsp_load;
            rsp_channel <= rsp_load ? cmd_channel_q : '0;
            rsp_data    <= (rsp_load && !mask_data) ? sample_q : '0;
            rsp_sop     <= rsp_load & cmd_sop_q;
            rsp_eop     <= rsp_load & cmd_eop_q;
        end
    end

endmodule

`default_nettype wire

// File: adc_sequencer.sv
// ADC sequencer control FSM
// Powers the ADC down and up, switches between normal and temperature-sensor
// mode, steps each command through its conversion and raises the load strobes
// for the response datapath
`timescale 1ns/1ps
`default_nettype none

module adc_sequencer (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      clk_in_pll_locked,
    input  wire                      cmd_valid,
    input  wire adc_stream_pkg::channel_t cmd_channel,
    input  wire                      dft_rise,
    input  wire                      dft_fall,
    input  wire                      eoc_fall,
    input  wire                      pwrdn_elapsed,
    input  wire                      tsen_elapsed,
    output adc_ctrl_pkg::ctrl_state_t state_next,
    output logic                     ts_select,
    output logic                     timer_clear,
    output logic                     timer_run,
    output logic                     cmd_take,
    output logic                     sample_take,
    output logic                     rsp_load
);

    import adc_ctrl_pkg::*;
    import adc_stream_pkg::*;

    ctrl_state_t state_q;
    logic        cmd_fetched;
    logic        pend;
    logic        prev_is_ts;
    logic        cmd_is_rclb;
    logic        cmd_is_ts;
    logic        needs_pwrdn;
    logic        fetch;
    logic        leave_pwrup;

    assign cmd_is_rclb = (cmd_channel == CH_RECAL);
    assign cmd_is_ts   = (cmd_channel == CH_TEMP);
    // Recalibration and any switch of mode both need a full power cycle
    assign needs_pwrdn = cmd_is_rclb | (prev_is_ts ^ cmd_is_ts);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE:           if (clk_in_pll_locked) state_next = PWRDWN;
            PWRDWN:         if (pwrdn_elapsed) state_next = PWRDWN_TSEN;
            PWRDWN_TSEN:    if (tsen_elapsed) state_next = PWRDWN_DONE;
            PWRDWN_DONE:    if (dft_rise) state_next = PWRUP_CH;
            PWRUP_CH:       if (dft_fall) state_next = PWRUP_SOC;
            PWRUP_SOC: begin
                if (eoc_fall) begin
                    if (cmd_fetched) begin
                        state_next = cmd_is_rclb ? PUTRESP : CONV;
                    end else begin
                        state_next = cmd_valid ? GETCMD : WAIT;
                    end
                end
            end
            WAIT:           if (cmd_valid) state_next = GETCMD_W;
            GETCMD_W:       state_next = needs_pwrdn ? PWRDWN : PRE_CONV;
            PRE_CONV:       if (eoc_fall) state_next = CONV;
            GETCMD: begin
                // A result still inside the hard block is drained before powering down
                if (needs_pwrdn) begin
                    state_next = pend ? WAIT_PEND : PWRDWN;
                end else begin
                    state_next = CONV;
                end
            end
            CONV:           if (eoc_fall) state_next = CONV_DLY1;
            CONV_DLY1:      state_next = PUTRESP;
            PUTRESP:        state_next = PUTRESP_DLY1;
            PUTRESP_DLY1:   state_next = PUTRESP_DLY2;
            PUTRESP_DLY2:   state_next = PUTRESP_DLY3;
            PUTRESP_DLY3: begin
                if (cmd_valid) begin
                    state_next = GETCMD;
                end else begin
                    state_next = pend ? WAIT_PEND : WAIT;
                end
            end
            WAIT_PEND:      if (eoc_fall) state_next = WAIT_PEND_DLY1;
            WAIT_PEND_DLY1: state_next = PUTRESP_PEND;
            PUTRESP_PEND:   state_next = cmd_valid ? GETCMD : WAIT;
            default:        state_next = IDLE;
        endcase
    end

    assign fetch       = ((state_q == GETCMD) || (state_q == GETCMD_W)) && (state_next == PWRDWN);
    assign leave_pwrup = (state_q == PWRUP_SOC) && (state_next != PWRUP_SOC);

    assign timer_clear = (state_next == PWRDWN) && (state_q != PWRDWN);
    assign timer_run   = (state_q == PWRDWN) || (state_q == PWRDWN_TSEN);

    // Recalibration keeps whatever mode the last real command selected
    assign ts_select = cmd_fetched & (cmd_is_rclb ? prev_is_ts : cmd_is_ts);

    assign cmd_take    = (state_q == PUTRESP);
    assign sample_take = ((state_q == CONV) && (state_next == CONV_DLY1) && pend) ||
                         ((state_q == WAIT_PEND) && (state_next == WAIT_PEND_DLY1));
    assign rsp_load    = ((state_q == PUTRESP) && pend && !cmd_is_rclb) ||
                         (state_q == PUTRESP_PEND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_fetched <= 1'b0;
            pend        <= 1'b0;
            prev_is_ts  <= 1'b0;
        end else begin
            if (fetch) begin
                cmd_fetched <= 1'b1;
            end else if (leave_pwrup) begin
                cmd_fetched <= 1'b0;
            end
            // Each finished conversion leaves its result one conversion behind
            if (cmd_take && !cmd_is_rclb) begin
                pend <= 1'b1;
            end else if (state_q == WAIT_PEND_DLY1) begin
                pend <= 1'b0;
            end
            if (cmd_take && !cmd_is_rclb) begin
                prev_is_ts <= cmd_is_ts;
            end
        end
    end

    // A result still waiting in the hard block would be lost by a power-down
    no_pend_at_pwrdn: assert property (
        @(posedge clk) disable iff (!rst_n) timer_clear |-> !pend
    );

endmodule

`default_nettype wire

// File: adc_stream_pkg.sv
// ADC command and sample stream definitions
// Channel and sample types, plus the channel codes with a special meaning
`default_nettype none

package adc_stream_pkg;

    typedef logic [4:0]  channel_t;
    typedef logic [11:0] sample_t;

    // Channel 31 requests a recalibration instead of a conversion
    localparam channel_t CH_RECAL = 5'd31;

    // On-die temperature sensor
    localparam channel_t CH_TEMP = 5'd17;

    // Idle channel driven while the ADC powers up
    localparam channel_t CH_PARK = 5'd30;

endpackage

`default_nettype wire

// File: flist.f
adc_ctrl_pkg.sv
adc_stream_pkg.sv
adc_edge_detect.sv
adc_pwrdn_timer.sv
adc_sequencer.sv
adc_pin_driver.sv
adc_response.sv
adc_ctrl_top.sv
tb_adc_hardblock.sv
tb_adc_ctrl.sv

// File: tb_adc_ctrl.sv
// Testbench for the ADC sequencer
// Drives host commands against a behavioral hard-block model and checks power
// sequencing, response order and data, temperature mode and recalibration
`timescale 1ns/1ps
`default_nettype none

module tb_adc_ctrl;

    import adc_stream_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int WAIT_LIMIT    = 1000;
    localparam int SEED          = 35997;
    localparam int PWRDN_CYCLES  = 64;
    localparam int TSEN_CYCLES   = 64;
    localparam bit MASK_TS_DATA  = 1'b0;
    localparam int PIN_USR_PWD   = 0;
    localparam int PIN_TSEN      = 1;
    localparam int PIN_SOC       = 2;
    localparam int PIN_CMD_READY = 3;

    typedef struct packed {
        channel_t channel;
        sample_t  data;
        logic     sop;
        logic     eop;
    } expect_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     clk_in_pll_locked;
    logic     cmd_valid;
    channel_t cmd_channel;
    logic     cmd_sop;
    logic     cmd_eop;
    wire      clk_dft;
    wire      eoc;
    sample_t  dout;
    logic     cmd_ready;
    logic     rsp_valid;
    channel_t rsp_channel;
    sample_t  rsp_data;
    logic     rsp_sop;
    logic     rsp_eop;
    channel_t chsel;
    logic     soc;
    logic     usr_pwd;
    logic     tsen;

    expect_t  expected[$];
    int       sent_count  = 0;
    int       ready_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    adc_ctrl_top #(
        .PWRDN_CYCLES (PWRDN_CYCLES),
        .TSEN_CYCLES  (TSEN_CYCLES),
        .MASK_TS_DATA (MASK_TS_DATA)
    ) u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .clk_in_pll_locked (clk_in_pll_locked),
        .cmd_valid         (cmd_valid),
        .cmd_channel       (cmd_channel),
        .cmd_sop           (cmd_sop),
        .cmd_eop           (cmd_eop),
        .clk_dft           (clk_dft),
        .eoc               (eoc),
        .dout              (dout),
        .cmd_ready         (cmd_ready),
        .rsp_valid         (rsp_valid),
        .rsp_channel       (rsp_channel),
        .rsp_data          (rsp_data),
        .rsp_sop           (rsp_sop),
        .rsp_eop           (rsp_eop),
        .chsel             (chsel),
        .soc               (soc),
        .usr_pwd           (usr_pwd),
        .tsen              (tsen)
    );

    tb_adc_hardblock u_hardblock (
        .clk     (clk),
        .chsel   (chsel),
        .soc     (soc),
        .tsen    (tsen),
        .clk_dft (clk_dft),
        .eoc     (eoc),
        .dout    (dout)
    );

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] want);
        if (actual !== want) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, actual, want);
            stop_run();
        end
    endtask

    function automatic logic pin_level(input int pin);
        case (pin)
            PIN_USR_PWD: return usr_pwd;
            PIN_TSEN:    return tsen;
            PIN_SOC:     return soc;
            default:     return cmd_ready;
        endcase
    endfunction

    // Always advances at least one cycle, so a pulse seen last cycle is not seen again
    task automatic wait_pin(input int pin, input logic level, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end while ((pin_level(pin) !== level) && (cycles < WAIT_LIMIT));
        if (pin_level(pin) !== level) begin
            fail_run($sformatf("Timed out waiting for %s", what));
        end
    endtask

    function automatic sample_t expected_code(input channel_t channel);
        if (channel != CH_TEMP) begin
            return 12'd256 + {7'd0, channel};
        end else if (MASK_TS_DATA) begin
            return '0;
        end else begin
            return 12'd3072 + {7'd0, channel};
        end
    endfunction

    task automatic drive_command(input channel_t channel, input logic sop, input logic eop);
        expect_t want;
        cmd_valid   = 1'b1;
        cmd_channel = channel;
        cmd_sop     = sop;
        cmd_eop     = eop;
        sent_count++;
        // A recalibration is acknowledged but has no result of its own
        if (channel != CH_RECAL) begin
            want.channel = channel;
            want.data    = expected_code(channel);
            want.sop     = sop;
            want.eop     = eop;
            expected.push_back(want);
        end
    endtask

    task automatic send_command(input channel_t channel, input logic sop, input logic eop);
        drive_command(channel, sop, eop);
        wait_pin(PIN_CMD_READY, 1'b1, $sformatf("cmd_ready for channel %0d", channel));
    endtask

    task automatic stop_commands();
        cmd_valid   = 1'b0;
        cmd_channel = '0;
        cmd_sop     = 1'b0;
        cmd_eop     = 1'b0;
    endtask

    task automatic wait_responses();
        int cycles;
        cycles = 0;
        while ((expected.size() != 0) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (expected.size() != 0) begin
            fail_run("Timed out waiting for the outstanding responses");
        end else begin
            check_value("cmd_ready pulse count", ready_count, sent_count);
        end
    endtask

    task automatic compare_response();
        expect_t want;
        if (expected.size() == 0) begin
            fail_run("A response pulse arrived with no command outstanding");
        end else begin
            want = expected.pop_front();
            check_value("rsp_channel", rsp_channel, want.channel);
            check_value("rsp_data", rsp_data, want.data);
            check_value("rsp_sop", rsp_sop, want.sop);
            check_value("rsp_eop", rsp_eop, want.eop);
        end
    endtask

    // Responses are compared as they arrive and cmd_ready pulses are counted
    always @(negedge clk) begin
        if (rst_n) begin
            if (cmd_ready) begin
                ready_count++;
            end
            if (rsp_valid) begin
                compare_response();
            end else begin
                check_value("idle rsp fields", {rsp_channel, rsp_data, rsp_sop, rsp_eop}, '0);
            end
        end
    end

    task automatic check_idle_pins();
        check_value("cmd_ready", cmd_ready, 0);
        check_value("rsp_valid", rsp_valid, 0);
        check_value("soc", soc, 0);
        check_value("tsen", tsen, 0);
        check_value("usr_pwd", usr_pwd, 1);
        check_value("chsel", chsel, CH_PARK);
    endtask

    task automatic check_reset_values();
        @(posedge clk);
        #DRIVE_DELAY;
        check_idle_pins();
        @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        check_idle_pins();
    endtask

    task automatic check_power_up();
        int cycles;
        clk_in_pll_locked = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end while ((usr_pwd === 1'b1) && (cycles < WAIT_LIMIT));
        if (usr_pwd === 1'b1) begin
            fail_run("Timed out waiting for usr_pwd to fall after the PLL locked");
        end else if (cycles < PWRDN_CYCLES + TSEN_CYCLES) begin
            fail_run($sformatf("usr_pwd fell after only %0d cycles of power-down", cycles));
        end else begin
            check_value("soc", soc, 0);
            wait_pin(PIN_SOC, 1'b1, "soc to rise after power-up");
            check_value("usr_pwd", usr_pwd, 0);
        end
    endtask

    task automatic run_back_to_back();
        channel_t channel;
        logic     sop;
        logic     eop;
        repeat (5) begin
            channel = $urandom_range(0, 15);
            sop     = $urandom_range(0, 1);
            eop     = $urandom_range(0, 1);
            send_command(channel, sop, eop);
        end
        stop_commands();
        wait_responses();
    endtask

    task automatic run_broken_stream();
        send_command(5'd12, 1'b1, 1'b1);
        stop_commands();
        wait_responses();
    endtask

    // Entering temperature mode takes a full power cycle with tsen set in between
    task automatic run_temperature_mode();
        drive_command(CH_TEMP, 1'b1, 1'b0);
        wait_pin(PIN_USR_PWD, 1'b1, "usr_pwd to rise for temperature mode");
        check_value("tsen", tsen, 0);
        wait_pin(PIN_TSEN, 1'b1, "tsen to rise");
        check_value("usr_pwd", usr_pwd, 1);
        wait_pin(PIN_USR_PWD, 1'b0, "usr_pwd to fall after the temperature power-down");
        wait_pin(PIN_SOC, 1'b1, "soc to rise in temperature mode");
        wait_pin(PIN_CMD_READY, 1'b1, "cmd_ready for the temperature command");
        send_command(5'd5, 1'b0, 1'b1);
        check_value("tsen", tsen, 0);
        stop_commands();
        wait_responses();
    endtask

    // Recalibrate once in normal mode and once in temperature mode
    task automatic run_recalibration();
        send_command(CH_RECAL, 1'b0, 1'b0);
        check_value("tsen", tsen, 0);
        send_command(CH_TEMP, 1'b0, 1'b0);
        send_command(CH_RECAL, 1'b1, 1'b1);
        check_value("tsen", tsen, 1);
        send_command(5'd3, 1'b1, 1'b0);
        send_command(5'd9, 1'b0, 1'b1);
        stop_commands();
        wait_responses();
    endtask

    initial begin
        rst_n             = 1'b0;
        clk_in_pll_locked = 1'b0;
        cmd_valid         = 1'b0;
        cmd_channel       = '0;
        cmd_sop           = 1'b0;
        cmd_eop           = 1'b0;
        void'($urandom(SEED));
        check_reset_values();
        check_power_up();
        run_back_to_back();
        run_broken_stream();
        run_temperature_mode();
        run_recalibration();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_adc_hardblock.sv
// ADC hard-block model
// Free-running clk_dft, one eoc pulse per clk_dft period while soc is high,
// and a dout code that trails the sampled channel by one conversion
`timescale 1ns/1ps
`default_nettype none

module tb_adc_hardblock (
    input  wire                           clk,
    input  wire adc_stream_pkg::channel_t chsel,
    input  wire                           soc,
    input  wire                           tsen,
    output logic                          clk_dft,
    output logic                          eoc,
    output adc_stream_pkg::sample_t       dout
);

    import adc_stream_pkg::*;

    logic [3:0] phase   = 4'd0;
    logic       eoc_q   = 1'b0;
    sample_t    dout_q  = '0;
    channel_t   last_ch = CH_PARK;
    logic       last_ts = 1'b0;

    // Normal codes sit at 256 and temperature-sensor codes at 3072, offset by the channel
    function automatic sample_t code_for(input channel_t channel, input logic ts);
        if (ts) begin
            return 12'd3072 + {7'd0, channel};
        end else begin
            return 12'd256 + {7'd0, channel};
        end
    endfunction

    // clk_dft is high for the upper half of a 16-cycle period
    assign clk_dft = phase[3];
    assign eoc     = eoc_q;
    assign dout    = dout_q;

    always @(posedge clk) begin
        phase <= phase + 4'd1;
        if (phase == 4'd7) begin
            // A conversion starts with the clk_dft rising edge
            eoc_q <= soc;
        end else if ((phase == 4'd11) && eoc_q) begin
            eoc_q   <= 1'b0;
            dout_q  <= code_for(last_ch, last_ts);
            last_ch <= chsel;
            last_ts <= tsen;
        end
    end

endmodule

`default_nettype wire
